// File: src/matmul_params.svh
`ifndef MATMUL_PARAMS_SVH
`define MATMUL_PARAMS_SVH

// element width in bits
`define MM_DWIDTH 16

// rows and columns of the array
`define MM_SIZE 4

// operand store and result buffer address width
`define MM_AWIDTH 2

// step counter
`define MM_STEP_WIDTH 5
`define MM_DONE_STEP 13

`endif

// File: src/matmul_pkg.sv
`include "matmul_params.svh"

package matmul_pkg;

  // one unsigned matrix element
  typedef logic [`MM_DWIDTH-1:0] elem_t;

  // full precision accumulator, two elements wide
  typedef logic [2*`MM_DWIDTH-1:0] acc_t;

  // one row or column of elements, lane 0 in the low bits
  typedef elem_t [`MM_SIZE-1:0] lane_vec_t;

  // clamp to all ones once the upper half carries anything
  function automatic elem_t saturate(input acc_t value);
    if (|value[2*`MM_DWIDTH-1:`MM_DWIDTH]) begin
      return '1;
    end
    return value[`MM_DWIDTH-1:0];
  endfunction

endpackage

// File: src/matmul_ctrl_if.sv
`timescale 1ns/1ps
`include "matmul_params.svh"

interface matmul_ctrl_if;

  // run timing
  logic [`MM_STEP_WIDTH-1:0]     step;
  logic                          run;
  logic                          flush;

  // operand store read side
  logic [`MM_AWIDTH-1:0]         rd_addr;
  logic                          feed_en;

  // one result select per pe, bit r*MM_SIZE+k for pe (r,k)
  logic [`MM_SIZE*`MM_SIZE-1:0]  pe_sel;

  modport seq (output step, run, flush, rd_addr, feed_en, pe_sel);

  modport feeder (input rd_addr, feed_en, flush);

  modport array (input pe_sel, flush);

  modport collector (input step, run);

endinterface

// File: src/matmul_sequencer.sv
`timescale 1ns/1ps
`include "matmul_params.svh"

module matmul_sequencer (
  input  logic          clk,
  input  logic          reset_0,
  input  logic          start,
  output logic          busy,
  output logic          done,
  matmul_ctrl_if.seq    ctrl
);

  // pe (3,3) is selected one step past the done step, in the done cycle
  localparam int SEL_BASE = `MM_DONE_STEP + 1 - 2 * (`MM_SIZE - 1);

  logic [`MM_STEP_WIDTH-1:0]    step_q;
  logic [`MM_SIZE*`MM_SIZE-1:0] pe_sel_d;

  always_ff @(posedge clk) begin
    if (reset_0) begin
      busy   <= 1'b0;
      done   <= 1'b0;
      step_q <= '0;
    end else begin
      done <= busy && (step_q == `MM_STEP_WIDTH'(`MM_DONE_STEP));
      if (start && !busy) begin
        busy   <= 1'b1;
        step_q <= '0;
      end else if (busy) begin
        // step keeps counting into the done cycle for the last select
        step_q <= step_q + 1'b1;
        if (step_q == `MM_STEP_WIDTH'(`MM_DONE_STEP)) begin
          busy <= 1'b0;
        end
      end else begin
        step_q <= '0;
      end
    end
  end

  // diagonal select wavefront
  always_comb begin
    for (int r = 0; r < `MM_SIZE; r++) begin
      for (int k = 0; k < `MM_SIZE; k++) begin
        pe_sel_d[r*`MM_SIZE+k] = (int'(step_q) == SEL_BASE + r + k);
      end
    end
  end

  assign ctrl.step    = step_q;
  assign ctrl.run     = busy;
  assign ctrl.rd_addr = step_q[`MM_AWIDTH-1:0];
  assign ctrl.feed_en = busy && (int'(step_q) < `MM_SIZE);
  assign ctrl.flush   = start && !busy;
  assign ctrl.pe_sel  = pe_sel_d;

endmodule

// File: src/operand_feeder.sv
`timescale 1ns/1ps
`include "matmul_params.svh"

module operand_feeder (
  input  logic                   clk,
  input  logic                   reset_0,
  input  logic                   we,
  input  logic [`MM_AWIDTH-1:0]  wr_addr,
  input  matmul_pkg::lane_vec_t  wr_data,
  matmul_ctrl_if.feeder          ctrl,
  output matmul_pkg::lane_vec_t  skewed
);

  import matmul_pkg::*;

  localparam int DEPTH = 2 ** `MM_AWIDTH;

  lane_vec_t store_mem [DEPTH];
  lane_vec_t rd_word;

  ////////////////////////////////////////////////////////////
  // operand store
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (we) begin
      store_mem[wr_addr] <= wr_data;
    end
  end

  // zeros outside the feed window
  always_ff @(posedge clk) begin
    if (reset_0) begin
      rd_word <= '0;
    end else if (ctrl.feed_en) begin
      rd_word <= store_mem[ctrl.rd_addr];
    end else begin
      rd_word <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // skew, lane i waits i more cycles
  ////////////////////////////////////////////////////////////

  assign skewed[0] = rd_word[0];

  for (genvar i = 1; i < `MM_SIZE; i++) begin : g_lane
    elem_t line_q [i];

    always_ff @(posedge clk) begin
      if (reset_0 || ctrl.flush) begin
        line_q <= '{default: '0};
      end else begin
        line_q[0] <= rd_word[i];
        for (int j = 1; j < i; j++) begin
          line_q[j] <= line_q[j-1];
        end
      end
    end

    assign skewed[i] = line_q[i-1];
  end

endmodule

// File: src/processing_element.sv
`timescale 1ns/1ps
`include "matmul_params.svh"

module processing_element (
  input  logic                clk,
  input  logic                reset_0,
  input  logic                flush,
  input  matmul_pkg::elem_t   in_a,
  input  matmul_pkg::elem_t   in_b,
  input  matmul_pkg::elem_t   in_c,
  input  logic                select,
  output matmul_pkg::elem_t   out_a,
  output matmul_pkg::elem_t   out_b,
  output matmul_pkg::elem_t   out_c
);

  import matmul_pkg::*;

  acc_t acc_q;
  acc_t product;

  assign product = acc_t'(in_a) * acc_t'(in_b);

  // forward operands east and south, accumulate every cycle
  always_ff @(posedge clk) begin
    if (reset_0 || flush) begin
      out_a <= '0;
      out_b <= '0;
      acc_q <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
      acc_q <= acc_q + product;
    end
  end

  // own result onto the row chain when selected
  assign out_c = select ? saturate(acc_q) : in_c;

endmodule

// File: src/systolic_array.sv
`timescale 1ns/1ps
`include "matmul_params.svh"

module systolic_array (
  input  logic                   clk,
  input  logic                   reset_0,
  matmul_ctrl_if.array           ctrl,
  input  matmul_pkg::lane_vec_t  a_lanes,
  input  matmul_pkg::lane_vec_t  b_lanes,
  output matmul_pkg::lane_vec_t  row_out
);

  import matmul_pkg::*;

  // a_east[r][k] enters pe (r,k) from the west
  elem_t a_east  [`MM_SIZE][`MM_SIZE+1];
  // b_south[r][k] enters pe (r,k) from the north
  elem_t b_south [`MM_SIZE+1][`MM_SIZE];
  // c_west[r][k] leaves pe (r,k) toward the west
  elem_t c_west  [`MM_SIZE][`MM_SIZE+1];

  ////////////////////////////////////////////////////////////
  // array edges
  ////////////////////////////////////////////////////////////

  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_edge_row
    assign a_east[r][0]        = a_lanes[r];
    // nothing enters the chain past the last column
    assign c_west[r][`MM_SIZE] = '0;
    assign row_out[r]          = c_west[r][0];
  end

  for (genvar k = 0; k < `MM_SIZE; k++) begin : g_edge_col
    assign b_south[0][k] = b_lanes[k];
  end

  ////////////////////////////////////////////////////////////
  // pe grid
  ////////////////////////////////////////////////////////////

  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_row
    for (genvar k = 0; k < `MM_SIZE; k++) begin : g_col
      processing_element pe_i (
        .clk     (clk),
        .reset_0 (reset_0),
        .flush   (ctrl.flush),
        .in_a    (a_east[r][k]),
        .in_b    (b_south[r][k]),
        .in_c    (c_west[r][k+1]),
        .select  (ctrl.pe_sel[r*`MM_SIZE+k]),
        .out_a   (a_east[r][k+1]),
        .out_b   (b_south[r+1][k]),
        .out_c   (c_west[r][k])
      );
    end
  end

endmodule

// File: src/result_collector.sv
`timescale 1ns/1ps
`include "matmul_params.svh"

module result_collector (
  input  logic                   clk,
  input  logic                   reset_0,
  matmul_ctrl_if.collector       ctrl,
  input  matmul_pkg::lane_vec_t  row_out,
  input  logic [`MM_AWIDTH-1:0]  rd_addr,
  output matmul_pkg::lane_vec_t  rd_data
);

  import matmul_pkg::*;

  // first step on which row 0 carries a result
  localparam int SEL_BASE = `MM_DONE_STEP + 1 - 2 * (`MM_SIZE - 1);

  lane_vec_t             res_mem [`MM_SIZE];
  lane_vec_t             rd_row;
  logic                  win_q;
  logic [`MM_SIZE-1:0]   wr_en;
  logic [`MM_AWIDTH-1:0] wr_col [`MM_SIZE];

  // chain values trail busy by one cycle
  always_ff @(posedge clk) begin
    if (reset_0) begin
      win_q <= 1'b0;
    end else begin
      win_q <= ctrl.run;
    end
  end

  // row r carries column step-SEL_BASE-r
  for (genvar r = 0; r < `MM_SIZE; r++) begin : g_row
    localparam int FIRST = SEL_BASE + r;
    assign wr_en[r]  = win_q && (int'(ctrl.step) >= FIRST)
                       && (int'(ctrl.step) < FIRST + `MM_SIZE);
    assign wr_col[r] = `MM_AWIDTH'(int'(ctrl.step) - FIRST);
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < `MM_SIZE; r++) begin
      if (wr_en[r]) begin
        res_mem[r][wr_col[r]] <= row_out[r];
      end
    end
  end

  // write-first, a read in the last write cycle sees the new element
  always_comb begin
    rd_row = res_mem[rd_addr];
    if (wr_en[rd_addr]) begin
      rd_row[wr_col[rd_addr]] = row_out[rd_addr];
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= rd_row;
  end

endmodule

// File: src/matmul_top.sv
`timescale 1ns/1ps
`include "matmul_params.svh"

module matmul_top (
  input  logic                              clk,
  input  logic                              reset_0,
  // operand load port
  input  logic [`MM_AWIDTH-1:0]             load_addr,
  input  logic [`MM_SIZE*`MM_DWIDTH-1:0]    load_data,
  input  logic                              load_a_we,
  input  logic                              load_b_we,
  // run control
  input  logic                              start,
  output logic                              busy,
  output logic                              done,
  // result read port
  input  logic [`MM_AWIDTH-1:0]             rd_addr,
  output logic [`MM_SIZE*`MM_DWIDTH-1:0]    rd_data
);

  matmul_pkg::lane_vec_t a_lanes;
  matmul_pkg::lane_vec_t b_lanes;
  matmul_pkg::lane_vec_t row_out;

  matmul_ctrl_if ctrl_if ();

  matmul_sequencer sequencer_i (
    .clk     (clk),
    .reset_0 (reset_0),
    .start   (start),
    .busy    (busy),
    .done    (done),
    .ctrl    (ctrl_if.seq)
  );

  ////////////////////////////////////////////////////////////
  // operand feeders, loads ignored while busy
  ////////////////////////////////////////////////////////////

  operand_feeder a_feeder (
    .clk     (clk),
    .reset_0 (reset_0),
    .we      (load_a_we && !busy),
    .wr_addr (load_addr),
    .wr_data (load_data),
    .ctrl    (ctrl_if.feeder),
    .skewed  (a_lanes)
  );

  operand_feeder b_feeder (
    .clk     (clk),
    .reset_0 (reset_0),
    .we      (load_b_we && !busy),
    .wr_addr (load_addr),
    .wr_data (load_data),
    .ctrl    (ctrl_if.feeder),
    .skewed  (b_lanes)
  );

  systolic_array array_i (
    .clk     (clk),
    .reset_0 (reset_0),
    .ctrl    (ctrl_if.array),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .row_out (row_out)
  );

  result_collector collector_i (
    .clk     (clk),
    .reset_0 (reset_0),
    .ctrl    (ctrl_if.collector),
    .row_out (row_out),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

// File: dv/matmul_chk.sv
`timescale 1ns/1ps

module matmul_chk (
  input logic clk,
  input logic reset_0,
  input logic start,
  input logic busy,
  input logic done
);

  // done is a single cycle pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (reset_0)
    done |=> !done)
    else $error("done stayed high for more than one cycle");

  // busy drops on the same edge that raises done
  a_busy_falls_with_done: assert property (@(posedge clk) disable iff (reset_0)
    $fell(busy) |-> done)
    else $error("busy fell without done");

  a_done_ends_busy: assert property (@(posedge clk) disable iff (reset_0)
    done |-> $fell(busy))
    else $error("done raised while busy did not fall");

  // an idle start raises busy on the next edge, and nothing else does
  a_start_to_busy: assert property (@(posedge clk) disable iff (reset_0)
    (start && !busy) |=> busy)
    else $error("busy did not rise one cycle after an idle start");

  a_busy_from_start: assert property (@(posedge clk) disable iff (reset_0)
    $rose(busy) |-> $past(start && !busy))
    else $error("busy rose without an idle start");

endmodule

bind matmul_top matmul_chk chk_i (
  .clk     (clk),
  .reset_0 (reset_0),
  .start   (start),
  .busy    (busy),
  .done    (done)
);

// File: dv/matmul_tb.sv
`timescale 1ns/1ps
`include "matmul_params.svh"

module matmul_tb;

  localparam int N_TESTS   = 7;
  localparam int CYCLE_MAX = N_TESTS * 40 + 100;
  localparam int DW        = `MM_DWIDTH;
  localparam int ACC_W     = 2 * `MM_DWIDTH;
  localparam int N         = `MM_SIZE;
  localparam int RUN_LEN   = 14;

  logic                   clk;
  logic                   reset_0;
  logic [`MM_AWIDTH-1:0]  load_addr;
  logic [N*DW-1:0]        load_data;
  logic                   load_a_we;
  logic                   load_b_we;
  logic                   start;
  logic                   busy;
  logic                   done;
  logic [`MM_AWIDTH-1:0]  rd_addr;
  logic [N*DW-1:0]        rd_data;

  // operands and expected product per test entry
  string         tab_name    [N_TESTS];
  bit            tab_disturb [N_TESTS];
  logic [DW-1:0] tab_a       [N_TESTS][N][N];
  logic [DW-1:0] tab_b       [N_TESTS][N][N];
  logic [DW-1:0] tab_c       [N_TESTS][N][N];

  int err_cnt   = 0;
  int check_cnt = 0;
  int cycle_cnt = 0;

  matmul_top matmul_top_i (
    .clk       (clk),
    .reset_0   (reset_0),
    .load_addr (load_addr),
    .load_data (load_data),
    .load_a_we (load_a_we),
    .load_b_we (load_b_we),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  always #20 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_MAX) begin
      $display("timeout reached after %0d cycles, run stopped", cycle_cnt);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////
  // table setup
  //////////////////////////////////////////////////////////////

  // sum of products at 32 bits then clamped to the element range
  function automatic logic [DW-1:0] expected_elem(input int t, input int r, input int k);
    logic [ACC_W-1:0] sum;
    sum = '0;
    for (int j = 0; j < N; j++) begin
      sum = sum + ACC_W'(tab_a[t][r][j]) * ACC_W'(tab_b[t][j][k]);
    end
    if (sum > ACC_W'({DW{1'b1}})) begin
      return '1;
    end
    return sum[DW-1:0];
  endfunction

  task automatic fill_table();
    tab_name = '{"identity", "small_random", "busy_ignore", "saturate_all",
                 "mixed_saturation", "zero_after_saturation", "small_random_again"};
    tab_disturb = '{0, 0, 1, 0, 0, 0, 0};
    for (int t = 0; t < N_TESTS; t++) begin
      for (int r = 0; r < N; r++) begin
        for (int c = 0; c < N; c++) begin
          case (t)
            0: begin
              tab_a[t][r][c] = (r == c) ? 16'd1 : 16'd0;
              tab_b[t][r][c] = 16'($urandom);
            end
            1, 2, 6: begin
              tab_a[t][r][c] = 16'($urandom_range(255, 0));
              tab_b[t][r][c] = 16'($urandom_range(255, 0));
            end
            3: begin
              // upper half set without wrapping the 32 bit sum
              tab_a[t][r][c] = 16'h4000 | 16'($urandom_range(16383, 0));
              tab_b[t][r][c] = 16'h4000 | 16'($urandom_range(16383, 0));
            end
            4: begin
              tab_a[t][r][c] = 16'($urandom_range(127, 0));
              tab_b[t][r][c] = 16'($urandom_range(511, 0));
            end
            default: begin
              tab_a[t][r][c] = 16'd0;
              tab_b[t][r][c] = 16'($urandom);
            end
          endcase
        end
      end
      for (int r = 0; r < N; r++) begin
        for (int k = 0; k < N; k++) begin
          tab_c[t][r][k] = expected_elem(t, r, k);
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////
  // bus tasks start and end 1 ns after a rising edge
  //////////////////////////////////////////////////////////////

  // A by columns first, then B by rows
  task automatic load_operands(input int t);
    logic [N*DW-1:0] word;
    int              w;
    for (int n = 0; n < 2 * N; n++) begin
      w = n % N;
      for (int i = 0; i < N; i++) begin
        word[i*DW +: DW] = (n < N) ? tab_a[t][i][w] : tab_b[t][w][i];
      end
      load_addr = `MM_AWIDTH'(w);
      load_data = word;
      load_a_we = (n < N);
      load_b_we = (n >= N);
      @(posedge clk);
      #1;
    end
    load_a_we = 1'b0;
    load_b_we = 1'b0;
  endtask

  task automatic run_matmul(input int t);
    int cycles;
    bit got_done;
    // edges counted after the start edge
    cycles = -1;
    got_done = 1'b0;
    start = 1'b1;
    while (!got_done && cycles < 40) begin
      @(posedge clk);
      #1;
      cycles++;
      start = 1'b0;
      load_a_we = 1'b0;
      load_b_we = 1'b0;
      check_cnt++;
      if (done) begin
        got_done = 1'b1;
        assert (cycles == RUN_LEN && !busy) else begin
          $display("Fail at %0t: done after %0d cycles with busy=%b, expected %0d and busy low",
                   $time, cycles, busy, RUN_LEN);
          err_cnt++;
        end
      end else begin
        assert (busy) else begin
          $display("Fail at %0t: busy low %0d cycles after start, before done", $time, cycles);
          err_cnt++;
        end
        // garbage loads and a second start in mid run
        if (tab_disturb[t] && cycles >= 2 && cycles <= 5) begin
          start = (cycles == 3);
          load_addr = `MM_AWIDTH'(cycles - 2);
          load_data = '1;
          load_a_we = 1'b1;
          load_b_we = 1'b1;
        end
      end
    end
    if (!got_done) begin
      $display("done never arrived within 40 cycles of start in test %0d", t);
      err_cnt++;
    end
  endtask

  // last row first, its final element lands in the done cycle
  task automatic read_results(input int t);
    for (int r = N - 1; r >= 0; r--) begin
      rd_addr = `MM_AWIDTH'(r);
      @(posedge clk);
      #1;
      for (int k = 0; k < N; k++) begin
        check_cnt++;
        assert (rd_data[k*DW +: DW] == tab_c[t][r][k]) else begin
          $display("Fail at %0t: test %0d C[%0d][%0d] is %h, expected %h",
                   $time, t, r, k, rd_data[k*DW +: DW], tab_c[t][r][k]);
          err_cnt++;
        end
      end
      assert (!done && !busy) else begin
        $display("Fail at %0t: done=%b busy=%b after the run, expected both low",
                 $time, done, busy);
        err_cnt++;
      end
    end
  endtask

  // no late done or busy after an ignored start
  task automatic watch_idle(input int n_cycles);
    repeat (n_cycles) begin
      @(posedge clk);
      #1;
      check_cnt++;
      assert (!done && !busy) else begin
        $display("Fail at %0t: done=%b busy=%b while idle, expected both low",
                 $time, done, busy);
        err_cnt++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////

  initial begin
    int test_errs;
    clk = 1'b0;
    reset_0 = 1'b1;
    load_addr = '0;
    load_data = '0;
    load_a_we = 1'b0;
    load_b_we = 1'b0;
    start = 1'b0;
    rd_addr = '0;
    void'($urandom(32'h27f1753d));
    fill_table();

    repeat (4) @(posedge clk);
    #1;
    reset_0 = 1'b0;
    check_cnt++;
    assert (!busy && !done) else begin
      $display("Fail at %0t: busy=%b done=%b after reset, expected both low", $time, busy, done);
      err_cnt++;
    end

    for (int t = 0; t < N_TESTS; t++) begin
      test_errs = err_cnt;
      load_operands(t);
      run_matmul(t);
      read_results(t);
      if (tab_disturb[t]) begin
        watch_idle(8);
      end
      test_errs = err_cnt - test_errs;
      if (test_errs == 0) begin
        $display("test %0d %s passed", t, tab_name[t]);
      end else begin
        $display("test %0d %s failed with %0d errors", t, tab_name[t], test_errs);
      end
    end

    $display("%0d tests, %0d checks, %0d errors", N_TESTS, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+src
src/matmul_pkg.sv
src/matmul_ctrl_if.sv
src/matmul_sequencer.sv
src/operand_feeder.sv
src/processing_element.sv
src/systolic_array.sv
src/result_collector.sv
src/matmul_top.sv
dv/matmul_chk.sv
dv/matmul_tb.sv

// File: Makefile
TOP = matmul_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
